//--- Makefile
TOP := tb_mem_island

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f mem_island_top.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "tests failed" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "all tests passed" sim.log || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir sim.log

//--- bank_arbiter.sv
/*
 * Bank arbiter
 * Decodes the narrow and wide port addresses and routes them to the
 * four SRAM banks, the narrow port always winning a shared wide bank
 */
`timescale 1ns/1ps

module bank_arbiter import mem_island_pkg::*; (
  input  narrow_req_t                 narrow_req_i,
  input  wide_req_t                   wide_req_i,
  output logic                        narrow_gnt_o,
  output logic                        wide_gnt_o,
  output bank_req_t [NumBanks-1:0]    bank_req_o,
  output logic                        narrow_acc_o,
  output logic                        wide_acc_o,
  output logic [BankIdxWidth-1:0]     narrow_sel_o,
  output logic [WideBankSelWidth-1:0] wide_sel_o
);

  narrow_addr_t        narrow_addr;
  wide_addr_t          wide_addr;
  logic                wbank_conflict;
  logic [NumBanks-1:0] narrow_hit;
  logic [NumBanks-1:0] wide_hit;

  // Same address word type, decoded per port width
  assign narrow_addr = narrow_req_i.addr.narrow;
  assign wide_addr   = wide_req_i.addr.wide;

  // Bank index is the wide-bank select above the sub-bank select
  assign narrow_sel_o = {narrow_addr.wbank, narrow_addr.sbank};
  assign wide_sel_o   = wide_addr.wbank;

  // A wide access needs both sub-banks, so any narrow hit on its wide bank blocks it
  assign wbank_conflict = narrow_req_i.req && (narrow_addr.wbank == wide_addr.wbank);

  assign narrow_gnt_o = narrow_req_i.req;
  assign wide_gnt_o   = wide_req_i.req && !wbank_conflict;

  assign narrow_acc_o = narrow_req_i.req && narrow_gnt_o;
  assign wide_acc_o   = wide_req_i.req && wide_gnt_o;

  always_comb begin
    for (int unsigned b = 0; b < NumBanks; b++) begin
      narrow_hit[b] = narrow_req_i.req && (narrow_sel_o == b);
      wide_hit[b]   = wide_gnt_o && (wide_addr.wbank == b / NumSubBanks);

      bank_req_o[b] = '0;
      if (narrow_hit[b]) begin
        bank_req_o[b].req   = 1'b1;
        bank_req_o[b].we    = narrow_req_i.we;
        bank_req_o[b].row   = narrow_addr.row;
        bank_req_o[b].wdata = narrow_req_i.wdata;
        bank_req_o[b].strb  = narrow_req_i.strb;
      end else if (wide_hit[b]) begin
        // Sub-bank s takes the s-th narrow slice of the wide word
        bank_req_o[b].req   = 1'b1;
        bank_req_o[b].we    = wide_req_i.we;
        bank_req_o[b].row   = wide_addr.row;
        bank_req_o[b].wdata =
          wide_req_i.wdata[(b % NumSubBanks)*NarrowWidth +: NarrowWidth];
        bank_req_o[b].strb  =
          wide_req_i.strb[(b % NumSubBanks)*NarrowStrbWidth +: NarrowStrbWidth];
      end
    end
  end

endmodule

//--- mem_island_checker.sv
/*
 * Memory island checker
 * Watches the DUT ports, keeps a byte-level reference memory and
 * checks grants, response timing and read data
 */
`timescale 1ns/1ps

module mem_island_checker import mem_island_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  narrow_req_t narrow_req_i,
  input  wide_req_t   wide_req_i,
  input  logic        narrow_gnt_i,
  input  logic        wide_gnt_i,
  input  narrow_rsp_t narrow_rsp_i,
  input  wide_rsp_t   wide_rsp_i,
  output int unsigned check_cnt_o,
  output int unsigned error_cnt_o
);

  logic [ByteWidth-1:0]   ref_mem [2**AddrWidth];
  logic [AddrWidth-1:0]   n_base;
  logic [AddrWidth-1:0]   w_base;
  logic                   wide_conflict;
  logic                   narrow_pend;
  logic                   narrow_rd;
  logic                   wide_pend;
  logic                   wide_rd;
  logic [NarrowWidth-1:0] narrow_exp;
  logic [WideWidth-1:0]   wide_exp;
  int unsigned            check_cnt = 0;
  int unsigned            error_cnt = 0;

  assign check_cnt_o = check_cnt;
  assign error_cnt_o = error_cnt;

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      narrow_pend = 1'b0;
      narrow_rd   = 1'b0;
      wide_pend   = 1'b0;
      wide_rd     = 1'b0;
    end else begin
      // Responses for what was accepted on the previous edge
      check_value("narrow rvalid", narrow_rsp_i.rvalid, narrow_pend);
      if (narrow_pend && narrow_rd) begin
        check_value("narrow rdata", narrow_rsp_i.rdata, narrow_exp);
      end
      check_value("wide rvalid", wide_rsp_i.rvalid, wide_pend);
      if (wide_pend && wide_rd) begin
        check_value("wide rdata", wide_rsp_i.rdata, wide_exp);
      end

      // Address bit 3 picks the wide bank in both views
      n_base = narrow_req_i.addr;
      w_base = wide_req_i.addr;
      n_base[1:0] = 2'b00;
      w_base[2:0] = 3'b000;
      wide_conflict = narrow_req_i.req && (n_base[3] == w_base[3]);
      check_value("narrow gnt", narrow_gnt_i, narrow_req_i.req);
      check_value("wide gnt", wide_gnt_i, wide_req_i.req && !wide_conflict);

      narrow_pend = narrow_req_i.req && narrow_gnt_i;
      narrow_rd   = !narrow_req_i.we;
      wide_pend   = wide_req_i.req && wide_gnt_i;
      wide_rd     = !wide_req_i.we;

      // Read data reflects memory before this edge's writes
      for (int i = 0; i < 4; i++) begin
        narrow_exp[i*8 +: 8] = ref_mem[n_base + i];
      end
      for (int i = 0; i < 8; i++) begin
        wide_exp[i*8 +: 8] = ref_mem[w_base + i];
      end

      if (narrow_pend && narrow_req_i.we) begin
        for (int i = 0; i < 4; i++) begin
          if (narrow_req_i.strb[i]) ref_mem[n_base + i] = narrow_req_i.wdata[i*8 +: 8];
        end
      end
      if (wide_pend && wide_req_i.we) begin
        for (int i = 0; i < 8; i++) begin
          if (wide_req_i.strb[i]) ref_mem[w_base + i] = wide_req_i.wdata[i*8 +: 8];
        end
      end
    end
  end

endmodule

//--- mem_island_pkg.sv
/*
 * Memory island shared definitions
 * Bank geometry, the two views of a port address and the request,
 * response and bank structs used between the island's blocks
 */
package mem_island_pkg;

  localparam int unsigned AddrWidth       = 10;
  localparam int unsigned ByteWidth       = 8;
  localparam int unsigned NarrowWidth     = 32;
  localparam int unsigned WideWidth       = 64;
  localparam int unsigned NarrowStrbWidth = NarrowWidth / ByteWidth;
  localparam int unsigned WideStrbWidth   = WideWidth / ByteWidth;
  localparam int unsigned NumWideBanks    = 2;
  localparam int unsigned NumSubBanks     = WideWidth / NarrowWidth;
  localparam int unsigned NumBanks        = NumWideBanks * NumSubBanks;
  localparam int unsigned WordsPerBank    = 64;
  localparam int unsigned RowWidth        = $clog2(WordsPerBank);

  localparam int unsigned WideBankSelWidth = $clog2(NumWideBanks);
  localparam int unsigned SubBankSelWidth  = $clog2(NumSubBanks);
  localparam int unsigned BankIdxWidth     = WideBankSelWidth + SubBankSelWidth;
  // Byte offsets fill the address below the bank selects
  localparam int unsigned WideOffWidth     = AddrWidth - RowWidth - WideBankSelWidth;
  localparam int unsigned NarrowOffWidth   = WideOffWidth - SubBankSelWidth;

  typedef struct packed {
    logic [RowWidth-1:0]         row;
    logic [WideBankSelWidth-1:0] wbank;
    logic [SubBankSelWidth-1:0]  sbank;
    logic [NarrowOffWidth-1:0]   offset;
  } narrow_addr_t;

  typedef struct packed {
    logic [RowWidth-1:0]         row;
    logic [WideBankSelWidth-1:0] wbank;
    logic [WideOffWidth-1:0]     offset;
  } wide_addr_t;

  // One address word, seen as a narrow or a wide access
  typedef union packed {
    narrow_addr_t narrow;
    wide_addr_t   wide;
  } mem_addr_u;

  typedef struct packed {
    logic                       req;
    logic                       we;
    mem_addr_u                  addr;
    logic [NarrowWidth-1:0]     wdata;
    logic [NarrowStrbWidth-1:0] strb;
  } narrow_req_t;

  typedef struct packed {
    logic                     req;
    logic                     we;
    mem_addr_u                addr;
    logic [WideWidth-1:0]     wdata;
    logic [WideStrbWidth-1:0] strb;
  } wide_req_t;

  typedef struct packed {
    logic                   rvalid;
    logic [NarrowWidth-1:0] rdata;
  } narrow_rsp_t;

  typedef struct packed {
    logic                 rvalid;
    logic [WideWidth-1:0] rdata;
  } wide_rsp_t;

  typedef struct packed {
    logic                       req;
    logic                       we;
    logic [RowWidth-1:0]        row;
    logic [NarrowWidth-1:0]     wdata;
    logic [NarrowStrbWidth-1:0] strb;
  } bank_req_t;

endpackage

//--- mem_island_top.f
mem_island_pkg.sv
sram_bank.sv
bank_arbiter.sv
rsp_assembler.sv
mem_island_top.sv
mem_island_checker.sv
tb_mem_island.sv

//--- mem_island_top.sv
/*
 * Memory island
 * Banked scratchpad with a narrow 32-bit and a wide 64-bit port
 * sharing four SRAM banks at a fixed one-cycle response latency
 */
`timescale 1ns/1ps

module mem_island_top import mem_island_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  narrow_req_t narrow_req_i,
  input  wide_req_t   wide_req_i,
  output logic        narrow_gnt_o,
  output logic        wide_gnt_o,
  output narrow_rsp_t narrow_rsp_o,
  output wide_rsp_t   wide_rsp_o
);

  bank_req_t [NumBanks-1:0]              bank_req;
  logic      [NumBanks-1:0][NarrowWidth-1:0] bank_rdata;
  logic                                  narrow_acc;
  logic                                  wide_acc;
  logic      [BankIdxWidth-1:0]          narrow_sel;
  logic      [WideBankSelWidth-1:0]      wide_sel;

  bank_arbiter bank_arbiter_i (
    .narrow_req_i ( narrow_req_i ),
    .wide_req_i   ( wide_req_i   ),
    .narrow_gnt_o ( narrow_gnt_o ),
    .wide_gnt_o   ( wide_gnt_o   ),
    .bank_req_o   ( bank_req     ),
    .narrow_acc_o ( narrow_acc   ),
    .wide_acc_o   ( wide_acc     ),
    .narrow_sel_o ( narrow_sel   ),
    .wide_sel_o   ( wide_sel     )
  );

  // Bank b sits in wide bank b / NumSubBanks at sub-bank b % NumSubBanks
  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    sram_bank sram_bank_i (
      .clk_i      ( clk_i         ),
      .rst_ni     ( rst_ni        ),
      .bank_req_i ( bank_req[b]   ),
      .rdata_o    ( bank_rdata[b] )
    );
  end

  rsp_assembler rsp_assembler_i (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .narrow_acc_i ( narrow_acc   ),
    .wide_acc_i   ( wide_acc     ),
    .narrow_sel_i ( narrow_sel   ),
    .wide_sel_i   ( wide_sel     ),
    .bank_rdata_i ( bank_rdata   ),
    .narrow_rsp_o ( narrow_rsp_o ),
    .wide_rsp_o   ( wide_rsp_o   )
  );

endmodule

//--- rsp_assembler.sv
/*
 * Response assembler
 * Delays acceptances and bank selects by one cycle, then steers bank
 * read data back onto the narrow and wide response ports
 */
`timescale 1ns/1ps

module rsp_assembler import mem_island_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 narrow_acc_i,
  input  logic                                 wide_acc_i,
  input  logic [BankIdxWidth-1:0]              narrow_sel_i,
  input  logic [WideBankSelWidth-1:0]          wide_sel_i,
  input  logic [NumBanks-1:0][NarrowWidth-1:0] bank_rdata_i,
  output narrow_rsp_t                          narrow_rsp_o,
  output wide_rsp_t                            wide_rsp_o
);

  logic                        narrow_acc_q;
  logic                        wide_acc_q;
  logic [BankIdxWidth-1:0]     narrow_sel_q;
  logic [WideBankSelWidth-1:0] wide_sel_q;

  // Matches the one-cycle bank read latency
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      narrow_acc_q <= 1'b0;
      wide_acc_q   <= 1'b0;
      narrow_sel_q <= '0;
      wide_sel_q   <= '0;
    end else begin
      narrow_acc_q <= narrow_acc_i;
      wide_acc_q   <= wide_acc_i;
      narrow_sel_q <= narrow_sel_i;
      wide_sel_q   <= wide_sel_i;
    end
  end

  assign narrow_rsp_o.rvalid = narrow_acc_q;
  assign narrow_rsp_o.rdata  = bank_rdata_i[narrow_sel_q];

  assign wide_rsp_o.rvalid = wide_acc_q;

  // Sub-bank 0 is the low half of the wide word
  always_comb begin
    for (int unsigned s = 0; s < NumSubBanks; s++) begin
      wide_rsp_o.rdata[s*NarrowWidth +: NarrowWidth] =
        bank_rdata_i[wide_sel_q*NumSubBanks + s];
    end
  end

  // Narrow and wide acceptances in one cycle use different wide banks
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    narrow_acc_i && wide_acc_i |->
      narrow_sel_i[BankIdxWidth-1 -: WideBankSelWidth] != wide_sel_i)
    else $error("narrow and wide port both accepted on wide bank %0d", wide_sel_i);

endmodule

//--- sram_bank.sv
/*
 * SRAM bank
 * Single-port 32-bit memory with byte write enables and a registered read
 */
`timescale 1ns/1ps

module sram_bank import mem_island_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  bank_req_t              bank_req_i,
  output logic [NarrowWidth-1:0] rdata_o
);

  logic [NarrowWidth-1:0] mem_q [WordsPerBank];

  // Byte lanes with strb low keep their old contents
  always_ff @(posedge clk_i) begin
    if (bank_req_i.req && bank_req_i.we) begin
      for (int unsigned i = 0; i < NarrowStrbWidth; i++) begin
        if (bank_req_i.strb[i]) begin
          mem_q[bank_req_i.row][i*ByteWidth +: ByteWidth] <=
            bank_req_i.wdata[i*ByteWidth +: ByteWidth];
        end
      end
    end
  end

  // Read data shows up the cycle after the request and holds until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (bank_req_i.req && !bank_req_i.we) begin
      rdata_o <= mem_q[bank_req_i.row];
    end
  end

endmodule

//--- tb_mem_island.sv
/*
 * Memory island testbench
 * Walks a stimulus table over both ports, with write data from an LFSR
 */
`timescale 1ns/1ps

module tb_mem_island import mem_island_pkg::*; ();

  typedef struct packed {
    logic                       n_req;
    logic                       n_we;
    logic [AddrWidth-1:0]       n_addr;
    logic [NarrowStrbWidth-1:0] n_strb;
    logic                       w_req;
    logic                       w_we;
    logic [AddrWidth-1:0]       w_addr;
    logic [WideStrbWidth-1:0]   w_strb;
  } stim_row_t;

  logic        clk_i;
  logic        rst_ni;
  narrow_req_t narrow_req;
  wide_req_t   wide_req;
  logic        narrow_gnt;
  logic        wide_gnt;
  narrow_rsp_t narrow_rsp;
  wide_rsp_t   wide_rsp;
  int unsigned check_cnt;
  int unsigned error_cnt;
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 0;
  logic [31:0] lfsr_q = 32'hee19738e;
  stim_row_t   rows [$];

  mem_island_top mem_island_top_i (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .narrow_req_i ( narrow_req ),
    .wide_req_i   ( wide_req   ),
    .narrow_gnt_o ( narrow_gnt ),
    .wide_gnt_o   ( wide_gnt   ),
    .narrow_rsp_o ( narrow_rsp ),
    .wide_rsp_o   ( wide_rsp   )
  );

  mem_island_checker mem_island_checker_i (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .narrow_req_i ( narrow_req ),
    .wide_req_i   ( wide_req   ),
    .narrow_gnt_i ( narrow_gnt ),
    .wide_gnt_i   ( wide_gnt   ),
    .narrow_rsp_i ( narrow_rsp ),
    .wide_rsp_i   ( wide_rsp   ),
    .check_cnt_o  ( check_cnt  ),
    .error_cnt_o  ( error_cnt  )
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
  endfunction

  task automatic take_bits(input int unsigned n, output logic [63:0] v);
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v[i]   = lfsr_q[0];
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  task automatic add_row(input logic n_req, input logic n_we, input logic [9:0] n_addr,
                         input logic [3:0] n_strb, input logic w_req, input logic w_we,
                         input logic [9:0] w_addr, input logic [7:0] w_strb);
    rows.push_back({n_req, n_we, n_addr, n_strb, w_req, w_we, w_addr, w_strb});
  endtask

  task automatic apply_row(input stim_row_t r);
    logic [63:0] bits;
    take_bits(NarrowWidth, bits);
    narrow_req.req   <= r.n_req;
    narrow_req.we    <= r.n_we;
    narrow_req.addr  <= r.n_addr;
    narrow_req.strb  <= r.n_strb;
    narrow_req.wdata <= bits[NarrowWidth-1:0];
    take_bits(WideWidth, bits);
    wide_req.req     <= r.w_req;
    wide_req.we      <= r.w_we;
    wide_req.addr    <= r.w_addr;
    wide_req.strb    <= r.w_strb;
    wide_req.wdata   <= bits;
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    rst_ni     = 1'b0;
    narrow_req = '0;
    wide_req   = '0;

    add_row(0, 0, 10'h000, 4'h0, 0, 0, 10'h000, 8'h00);
    add_row(0, 0, 10'h000, 4'h0, 0, 0, 10'h000, 8'h00);
    // Narrow full write, partial write, read back
    add_row(1, 1, 10'h010, 4'hf, 0, 0, 10'h000, 8'h00);
    add_row(1, 1, 10'h010, 4'h5, 0, 0, 10'h000, 8'h00);
    add_row(1, 0, 10'h010, 4'h0, 0, 0, 10'h000, 8'h00);
    // Wide write, narrow reads of both halves
    add_row(0, 0, 10'h000, 4'h0, 1, 1, 10'h028, 8'hff);
    add_row(1, 0, 10'h028, 4'h0, 0, 0, 10'h000, 8'h00);
    add_row(1, 0, 10'h02c, 4'h0, 0, 0, 10'h000, 8'h00);
    // Adjacent narrow writes, one wide read
    add_row(1, 1, 10'h040, 4'hf, 0, 0, 10'h000, 8'h00);
    add_row(1, 1, 10'h044, 4'hf, 0, 0, 10'h000, 8'h00);
    add_row(0, 0, 10'h000, 4'h0, 1, 0, 10'h040, 8'h00);
    // Same wide bank, wide waits for the narrow port
    add_row(1, 0, 10'h010, 4'h0, 1, 1, 10'h000, 8'hff);
    add_row(1, 0, 10'h000, 4'h0, 0, 0, 10'h000, 8'h00);
    add_row(1, 0, 10'h004, 4'h0, 0, 0, 10'h000, 8'h00);
    add_row(0, 0, 10'h000, 4'h0, 1, 1, 10'h000, 8'h5a);
    add_row(0, 0, 10'h000, 4'h0, 1, 0, 10'h000, 8'h00);
    add_row(1, 1, 10'h044, 4'hf, 1, 0, 10'h040, 8'h00);
    // Different wide banks in the same cycle
    add_row(1, 1, 10'h030, 4'hf, 1, 1, 10'h038, 8'hff);
    add_row(1, 1, 10'h034, 4'hf, 1, 0, 10'h028, 8'h00);
    add_row(1, 0, 10'h03c, 4'h0, 1, 0, 10'h030, 8'h00);
    add_row(0, 0, 10'h000, 4'h0, 0, 0, 10'h000, 8'h00);
    add_row(0, 0, 10'h000, 4'h0, 0, 0, 10'h000, 8'h00);
    cycle_limit = rows.size() * 3 + 50;

    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    foreach (rows[i]) begin
      apply_row(rows[i]);
      @(posedge clk_i);
      // Narrow part was accepted, only the wide request is held
      while (wide_req.req && !wide_gnt) begin
        narrow_req.req <= 1'b0;
        @(posedge clk_i);
      end
    end
    narrow_req.req <= 1'b0;
    wide_req.req   <= 1'b0;
    repeat (3) @(posedge clk_i);

    $display("checks %0d, errors %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
